// ==== source/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// ====================
// Execute stage sizing
// ====================

`define EXEC_XLEN 32
`define EXEC_RADDR_W 5

// One restoring step per quotient bit.
`define EXEC_DIV_ITER `EXEC_XLEN

`endif

// ==== source/exec_pkg.sv ====
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LOAD, OP_STORE,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } exec_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [3:0] {
        CAUSE_INSTR_MISALIGN = 4'd0,
        CAUSE_LOAD_MISALIGN  = 4'd4,
        CAUSE_STORE_MISALIGN = 4'd6,
        CAUSE_NONE           = 4'd15 // Not a RISC-V code, marks no trap.
    } exc_cause_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

    // ====================
    // Stage records
    // ====================

    typedef struct packed {
        exec_op_e                  op;
        logic [`EXEC_XLEN-1:0]     pc;
        logic [`EXEC_XLEN-1:0]     rs1_data;
        logic [`EXEC_XLEN-1:0]     rs2_data;
        logic [`EXEC_XLEN-1:0]     imm;
        logic                      use_imm;  // Operand B is imm instead of rs2.
        logic [`EXEC_RADDR_W-1:0]  waddr;
        mem_size_e                 size;
    } exec_req_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]     pc;
        logic                      wren;
        logic [`EXEC_RADDR_W-1:0]  waddr;
        logic [`EXEC_XLEN-1:0]     wdata;
        logic                      jump;
        logic [`EXEC_XLEN-1:0]     target;
        logic                      load;
        logic                      store;
        mem_size_e                 size;
        logic [`EXEC_XLEN-1:0]     address;
        logic [3:0]                byteenable;
        logic [`EXEC_XLEN-1:0]     sdata;
        logic                      exception;
        exc_cause_e                cause;
    } exec_rsp_t;

endpackage

`default_nettype wire

// ==== source/exec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_alu import exec_pkg::*; (
    input  exec_op_e              op,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    output logic [`EXEC_XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];                 // RV32 shifts only look at 5 bits.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            OP_SUB:   result = a - b;
            OP_AND:   result = a & b;
            OP_OR:    result = a | b;
            OP_XOR:   result = a ^ b;
            OP_SLL:   result = a << shamt;
            OP_SRL:   result = a >> shamt;
            OP_SRA:   result = $signed(a) >>> shamt;
            OP_SLT:   result = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            OP_SLTU:  result = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            OP_LUI:   result = b;                     // Immediate is already shifted up.
            OP_AUIPC: result = pc + b;
            default:  result = a + b;                 // Add, and the load address sum.
        endcase
    end

endmodule

`default_nettype wire

// ==== source/exec_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_branch import exec_pkg::*; (
    input  exec_op_e              op,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    input  logic [`EXEC_XLEN-1:0] imm,
    output logic                  jump,
    output logic [`EXEC_XLEN-1:0] target
);

    logic                  eq;
    logic                  lt;
    logic                  ltu;
    logic                  taken;
    logic [`EXEC_XLEN-1:0] jalr_sum;

    assign eq  = a == b;
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        case (op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt;
            OP_BGE:  taken = !lt;
            OP_BLTU: taken = ltu;
            OP_BGEU: taken = !ltu;
            OP_JAL,
            OP_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jump     = taken;
    assign jalr_sum = a + imm;

    // JALR drops bit 0 of the register-relative target.
    assign target = (op == OP_JALR) ? {jalr_sum[`EXEC_XLEN-1:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

// ==== source/exec_agu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_agu import exec_pkg::*; (
    input  exec_op_e              op,
    input  mem_size_e             size,
    input  logic [`EXEC_XLEN-1:0] base,
    input  logic [`EXEC_XLEN-1:0] imm,
    input  logic [`EXEC_XLEN-1:0] store_data,
    output logic [`EXEC_XLEN-1:0] address,
    output logic [3:0]            byteenable,
    output logic [`EXEC_XLEN-1:0] sdata,
    output logic                  misaligned
);

    logic       mem_op;
    logic [1:0] offset;
    logic [3:0] mask;
    logic       bad_align;

    assign address = base + imm;
    assign offset  = address[1:0];
    assign mem_op  = (op == OP_LOAD) || (op == OP_STORE);

    always_comb begin
        case (size)
            SIZE_BYTE: mask = 4'b0001 << offset;
            SIZE_HALF: mask = 4'b0011 << {offset[1], 1'b0};
            default:   mask = 4'b1111;
        endcase
    end

    assign byteenable = mem_op ? mask : 4'b0000;   // No lanes for non-memory ops.
    assign sdata      = store_data << {offset, 3'b000};

    assign bad_align  = ((size == SIZE_HALF) && offset[0]) ||
                        ((size == SIZE_WORD) && (offset != 2'b00));
    assign misaligned = mem_op && bad_align;

endmodule

`default_nettype wire

// ==== source/exec_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_divider import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  exec_op_e              op,
    input  logic [`EXEC_XLEN-1:0] dividend,
    input  logic [`EXEC_XLEN-1:0] divisor,
    output logic                  done,
    output logic [`EXEC_XLEN-1:0] result
);

    localparam int CNT_W = $clog2(`EXEC_DIV_ITER);

    div_state_e            state;
    logic [CNT_W-1:0]      cnt;
    logic [`EXEC_XLEN-1:0] quo;
    logic [`EXEC_XLEN-1:0] rem;
    logic [`EXEC_XLEN-1:0] dvs;
    logic [`EXEC_XLEN:0]   rem_sh;
    logic [`EXEC_XLEN:0]   diff;
    logic [`EXEC_XLEN-1:0] a_mag;
    logic [`EXEC_XLEN-1:0] b_mag;
    logic [`EXEC_XLEN-1:0] quo_fix;
    logic [`EXEC_XLEN-1:0] rem_fix;
    logic                  is_signed;
    logic                  neg_q;
    logic                  neg_r;
    logic                  by_zero;
    logic                  want_rem;

    assign is_signed = (op == OP_DIV) || (op == OP_REM);
    assign a_mag     = (is_signed && dividend[`EXEC_XLEN-1]) ? -dividend : dividend;
    assign b_mag     = (is_signed && divisor[`EXEC_XLEN-1]) ? -divisor : divisor;

    assign rem_sh = {rem, quo[`EXEC_XLEN-1]};      // Bring down the next dividend bit.
    assign diff   = rem_sh - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: if (start) begin
                    state <= DIV_BUSY;
                    cnt   <= '0;
                end
                DIV_BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`EXEC_DIV_ITER - 1)) state <= DIV_DONE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == DIV_IDLE) && start) begin
            quo      <= a_mag;
            rem      <= '0;
            dvs      <= b_mag;
            neg_q    <= is_signed && (dividend[`EXEC_XLEN-1] ^ divisor[`EXEC_XLEN-1]);
            neg_r    <= is_signed && dividend[`EXEC_XLEN-1];
            by_zero  <= divisor == '0;
            want_rem <= (op == OP_REM) || (op == OP_REMU);
        end else if (state == DIV_BUSY) begin
            rem <= diff[`EXEC_XLEN] ? rem_sh[`EXEC_XLEN-1:0] : diff[`EXEC_XLEN-1:0];
            quo <= {quo[`EXEC_XLEN-2:0], !diff[`EXEC_XLEN]};
        end
    end

    // Overflow needs no special case: the magnitude quotient of 2^31 / 1 is
    // already the most negative value, and the remainder comes out zero.
    assign quo_fix = by_zero ? '1 : (neg_q ? -quo : quo);
    assign rem_fix = neg_r ? -rem : rem;          // Remainder takes the dividend's sign.

    assign result = want_rem ? rem_fix : quo_fix;
    assign done   = state == DIV_DONE;

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module execute_stage import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  exec_req_t             req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output exec_rsp_t             rsp,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output exec_op_e              alu_op,
    output logic [`EXEC_XLEN-1:0] alu_a,
    output logic [`EXEC_XLEN-1:0] alu_b,
    input  logic [`EXEC_XLEN-1:0] alu_result,
    input  logic                  br_jump,
    input  logic [`EXEC_XLEN-1:0] br_target,
    input  logic [`EXEC_XLEN-1:0] agu_address,
    input  logic [3:0]            agu_byteenable,
    input  logic [`EXEC_XLEN-1:0] agu_sdata,
    input  logic                  agu_misaligned,
    output logic                  div_start,
    input  logic                  div_done,
    input  logic [`EXEC_XLEN-1:0] div_result
);

    logic      live;
    logic      div_run;
    logic      is_div;
    logic      is_link;
    logic      writes;
    logic      out_free;
    logic      accept;
    exec_rsp_t nxt;

    // ====================
    // Dispatch
    // ====================

    assign alu_op = req.op;
    assign alu_a  = req.rs1_data;
    assign alu_b  = req.use_imm ? req.imm : req.rs2_data;

    assign is_div  = (req.op == OP_DIV) || (req.op == OP_DIVU) ||
                     (req.op == OP_REM) || (req.op == OP_REMU);
    assign is_link = (req.op == OP_JAL) || (req.op == OP_JALR);

    always_comb begin
        case (req.op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_STORE: writes = 1'b0;
            default: writes = 1'b1;
        endcase
    end

    // The output register can take a new record this cycle.
    assign out_free  = !rsp_valid || rsp_ready;
    assign req_ready = live && out_free && (!is_div || div_done);
    assign accept    = req_valid && req_ready;

    // A finished divide that cannot be stored is simply run again.
    assign div_start = live && req_valid && is_div && !div_run;

    // ====================
    // Result select
    // ====================

    always_comb begin
        nxt            = '0;
        nxt.pc         = req.pc;
        nxt.waddr      = req.waddr;
        nxt.wren       = writes && (req.waddr != '0);
        nxt.jump       = br_jump;
        nxt.target     = br_target;
        nxt.load       = req.op == OP_LOAD;
        nxt.store      = req.op == OP_STORE;
        nxt.size       = req.size;
        nxt.address    = agu_address;
        nxt.byteenable = agu_byteenable;
        nxt.sdata      = agu_sdata;
        nxt.cause      = CAUSE_NONE;

        if (is_link) begin
            nxt.wdata = req.pc + `EXEC_XLEN'(4);
        end else if (is_div) begin
            nxt.wdata = div_result;
        end else begin
            nxt.wdata = alu_result;
        end

        if (agu_misaligned) begin
            nxt.exception = 1'b1;
            nxt.cause     = nxt.load ? CAUSE_LOAD_MISALIGN : CAUSE_STORE_MISALIGN;
            nxt.load      = 1'b0;
            nxt.store     = 1'b0;
            nxt.wren      = 1'b0;
        end else if (br_jump && br_target[1]) begin
            nxt.exception = 1'b1;                   // Target not on a 4-byte boundary.
            nxt.cause     = CAUSE_INSTR_MISALIGN;
            nxt.jump      = 1'b0;
            nxt.wren      = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            live      <= 1'b0;
            div_run   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            live <= 1'b1;
            if (div_start) begin
                div_run <= 1'b1;
            end else if (div_done) begin
                div_run <= 1'b0;
            end
            if (accept) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) rsp <= nxt;
    end

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module execute_unit import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  exec_req_t req,
    input  logic      req_valid,
    output logic      req_ready,
    output exec_rsp_t rsp,
    output logic      rsp_valid,
    input  logic      rsp_ready
);

    exec_op_e              alu_op;
    logic [`EXEC_XLEN-1:0] alu_a;
    logic [`EXEC_XLEN-1:0] alu_b;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  br_jump;
    logic [`EXEC_XLEN-1:0] br_target;
    logic [`EXEC_XLEN-1:0] agu_address;
    logic [3:0]            agu_byteenable;
    logic [`EXEC_XLEN-1:0] agu_sdata;
    logic                  agu_misaligned;
    logic                  div_start;
    logic                  div_done;
    logic [`EXEC_XLEN-1:0] div_result;

    execute_stage u_stage (
        .clk, .rst, .req, .req_valid, .req_ready, .rsp, .rsp_valid, .rsp_ready,
        .alu_op, .alu_a, .alu_b, .alu_result, .br_jump, .br_target,
        .agu_address, .agu_byteenable, .agu_sdata, .agu_misaligned,
        .div_start, .div_done, .div_result
    );

    exec_alu u_alu (
        .op(alu_op), .pc(req.pc), .a(alu_a), .b(alu_b), .result(alu_result)
    );

    exec_branch u_branch (
        .op(alu_op), .pc(req.pc), .a(alu_a), .b(alu_b), .imm(req.imm),
        .jump(br_jump), .target(br_target)
    );

    // Address is rs1 plus imm, store data always comes from rs2.
    exec_agu u_agu (
        .op(alu_op), .size(req.size), .base(alu_a), .imm(req.imm),
        .store_data(req.rs2_data), .address(agu_address),
        .byteenable(agu_byteenable), .sdata(agu_sdata), .misaligned(agu_misaligned)
    );

    exec_divider u_divider (
        .clk, .rst, .start(div_start), .op(alu_op), .dividend(alu_a),
        .divisor(alu_b), .done(div_done), .result(div_result)
    );

endmodule

`default_nettype wire

// ==== sim/execute_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module execute_tb import exec_pkg::*; ();

    localparam int     XLEN         = `EXEC_XLEN;
    localparam int     NUM_REQ      = 240;
    localparam int     DIV_WAIT_MIN = `EXEC_DIV_ITER + 1;
    localparam longint TIMEOUT_NS   = longint'(NUM_REQ) * (`EXEC_DIV_ITER + 4) * 2 * 8;

    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic      clk;
    logic      rst;
    exec_req_t req;
    logic      req_valid;
    logic      req_ready;
    exec_rsp_t rsp;
    logic      rsp_valid;
    logic      rsp_ready;

    logic [15:0] lfsr = 16'd49170;
    exec_rsp_t   exp_q[$];
    exec_rsp_t   prev_rsp;
    exec_req_t   next_req;
    logic        prev_hold;
    logic        prev_accept;
    logic        pending;
    int          div_wait;
    int          rst_cycles;
    int          issued;
    int          taken_cnt;
    int          value_errors;
    int          protocol_errors;

    execute_unit DUT (
        .clk, .rst, .req, .req_valid, .req_ready, .rsp, .rsp_valid, .rsp_ready
    );

    always #4 clk = ~clk;

    // ====================
    // Random source and reference model
    // ====================

    function automatic logic [XLEN-1:0] next_bits(input int n);
        logic [XLEN-1:0] v;
        logic            fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1.
            lfsr = {lfsr[14:0], fb};
            v    = {v[XLEN-2:0], fb};
        end
        return v;
    endfunction

    function automatic logic is_divide(input exec_op_e op);
        return (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
    endfunction

    function automatic logic [XLEN-1:0] alu_value(input exec_op_e op, input logic [XLEN-1:0] pc,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLL:   return a << b[4:0];
            OP_SRL:   return a >> b[4:0];
            OP_SRA:   return $signed(a) >>> b[4:0];
            OP_SLT:   return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLTU:  return {{(XLEN-1){1'b0}}, a < b};
            OP_LUI:   return b;
            OP_AUIPC: return pc + b;
            default:  return a + b;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] div_value(input exec_op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] q;
        if (b == '0) begin
            return (op == OP_DIV || op == OP_DIVU) ? '1 : a;
        end
        if ((op == OP_DIV || op == OP_REM) && a == MOST_NEG && b == '1) begin
            return (op == OP_DIV) ? a : '0;   // Signed overflow case.
        end
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            OP_DIVU: return a / b;
            OP_REMU: return a % b;
            OP_DIV:  q = sa / sb;
            default: q = sa % sb;
        endcase
        return q;
    endfunction

    function automatic exec_rsp_t expected_rsp(input exec_req_t r);
        exec_rsp_t       e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        logic [3:0]      lanes;
        logic            mem;
        logic            bad;
        a            = r.rs1_data;
        b            = r.use_imm ? r.imm : r.rs2_data;
        addr         = a + r.imm;
        e            = '0;
        e.pc         = r.pc;
        e.waddr      = r.waddr;
        e.size       = r.size;
        e.address    = addr;
        e.sdata      = r.rs2_data << {addr[1:0], 3'b000};
        e.load       = r.op == OP_LOAD;
        e.store      = r.op == OP_STORE;
        e.cause      = CAUSE_NONE;
        mem          = e.load || e.store;
        case (r.size)
            SIZE_BYTE: lanes = 4'b0001 << addr[1:0];
            SIZE_HALF: lanes = addr[1] ? 4'b1100 : 4'b0011;
            default:   lanes = 4'b1111;
        endcase
        e.byteenable = mem ? lanes : 4'b0000;
        bad = ((r.size == SIZE_HALF) && addr[0]) ||
              ((r.size == SIZE_WORD) && (addr[1:0] != 2'b00));
        case (r.op)
            OP_BEQ:          e.jump = a == b;
            OP_BNE:          e.jump = a != b;
            OP_BLT:          e.jump = $signed(a) < $signed(b);
            OP_BGE:          e.jump = $signed(a) >= $signed(b);
            OP_BLTU:         e.jump = a < b;
            OP_BGEU:         e.jump = a >= b;
            OP_JAL, OP_JALR: e.jump = 1'b1;
            default:         e.jump = 1'b0;
        endcase
        e.target = (r.op == OP_JALR) ? ((a + r.imm) & ~XLEN'(1)) : r.pc + r.imm;
        case (r.op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_STORE: e.wren = 1'b0;
            default: e.wren = r.waddr != '0;
        endcase
        if (r.op == OP_JAL || r.op == OP_JALR) begin
            e.wdata = r.pc + XLEN'(4);   // Link address.
        end else if (is_divide(r.op)) begin
            e.wdata = div_value(r.op, a, b);
        end else begin
            e.wdata = alu_value(r.op, r.pc, a, b);
        end
        if (mem && bad) begin
            e.exception = 1'b1;
            e.cause     = e.load ? CAUSE_LOAD_MISALIGN : CAUSE_STORE_MISALIGN;
            e.load      = 1'b0;
            e.store     = 1'b0;
            e.wren      = 1'b0;
        end else if (e.jump && e.target[1]) begin
            e.exception = 1'b1;
            e.cause     = CAUSE_INSTR_MISALIGN;
            e.jump      = 1'b0;
            e.wren      = 1'b0;
        end
        return e;
    endfunction

    task automatic build_request(output exec_req_t r);
        logic [2:0] shape;
        r.op       = exec_op_e'(5'(next_bits(5) % 32'd26));
        r.pc       = next_bits(XLEN) & ~XLEN'(3);
        r.rs1_data = next_bits(XLEN);
        r.rs2_data = next_bits(XLEN);
        r.imm      = next_bits(XLEN);
        r.use_imm  = 1'(next_bits(1));
        r.waddr    = 5'(next_bits(5));
        r.size     = mem_size_e'(2'(next_bits(2) % 32'd3));
        shape      = 3'(next_bits(3));
        case (shape)
            3'd0: begin
                r.rs2_data = '0;   // Zero operand B gives a division by zero.
                r.imm      = '0;
            end
            3'd1: begin
                r.rs1_data = MOST_NEG;
                r.rs2_data = '1;
                r.imm      = '1;
            end
            3'd2: begin
                r.rs2_data = r.rs1_data;
                r.imm      = r.rs1_data;
            end
            3'd3: r.waddr = '0;
            default: ;
        endcase
    endtask

    // ====================
    // Checks
    // ====================

    task automatic check_field(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("error at %0t: rsp.%s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic protocol_fail(input string msg);
        protocol_errors++;
        $display("protocol error at %0t: %s", $time, msg);
    endtask

    task automatic check_rsp(input exec_rsp_t exp, input exec_rsp_t act);
        check_field("pc", exp.pc, act.pc);
        check_field("wren", XLEN'(exp.wren), XLEN'(act.wren));
        check_field("waddr", XLEN'(exp.waddr), XLEN'(act.waddr));
        check_field("wdata", exp.wdata, act.wdata);
        check_field("jump", XLEN'(exp.jump), XLEN'(act.jump));
        check_field("target", exp.target, act.target);
        check_field("load", XLEN'(exp.load), XLEN'(act.load));
        check_field("store", XLEN'(exp.store), XLEN'(act.store));
        check_field("size", XLEN'(exp.size), XLEN'(act.size));
        check_field("address", exp.address, act.address);
        check_field("byteenable", XLEN'(exp.byteenable), XLEN'(act.byteenable));
        check_field("sdata", exp.sdata, act.sdata);
        check_field("exception", XLEN'(exp.exception), XLEN'(act.exception));
        check_field("cause", XLEN'(exp.cause), XLEN'(act.cause));
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (rst_cycles > 0) begin
                assert (!rsp_valid && !req_ready)
                    else protocol_fail("rsp_valid or req_ready high during reset");
            end
            rst_cycles++;
            prev_hold   = 1'b0;
            prev_accept = 1'b0;
            div_wait    = 0;
        end else begin
            if (prev_hold) begin
                assert (rsp_valid && rsp === prev_rsp)
                    else protocol_fail("held result changed while rsp_ready was low");
            end
            if (prev_accept) begin
                assert (rsp_valid) else protocol_fail("rsp_valid low in the cycle after accept");
            end
            assert (!(rsp_valid && !rsp_ready && req_ready))
                else protocol_fail("req_ready high while the result register was blocked");
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    protocol_fail("result delivered with no request waiting for it");
                end else begin
                    check_rsp(exp_q.pop_front(), rsp);
                    taken_cnt <= taken_cnt + 1;
                end
            end
            if (req_valid && is_divide(req.op)) begin
                if (req_ready) begin
                    assert (div_wait >= DIV_WAIT_MIN)
                        else protocol_fail("divide accepted before the divider could finish");
                    div_wait = 0;
                end else begin
                    div_wait++;
                end
            end else begin
                div_wait = 0;
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(expected_rsp(req));
            end
            prev_accept = req_valid && req_ready;
            prev_hold   = rsp_valid && !rsp_ready;
            prev_rsp    = rsp;
        end
    end

    // ====================
    // Stimulus and end of run
    // ====================

    initial begin
        clk             = 1'b0;
        rst             = 1'b0;
        req             = '0;
        req_valid       = 1'b0;
        rsp_ready       = 1'b0;
        pending         = 1'b0;
        issued          = 0;
        taken_cnt       = 0;
        rst_cycles      = 0;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;

        while (issued < NUM_REQ || pending) begin
            @(posedge clk);
            if (req_valid && req_ready) begin
                pending = 1'b0;
            end
            rsp_ready <= (next_bits(2) != '0);   // High three cycles in four.
            if (!pending && issued < NUM_REQ && next_bits(1) != '0) begin
                build_request(next_req);
                req       <= next_req;
                req_valid <= 1'b1;
                pending   = 1'b1;
                issued++;
            end else if (!pending) begin
                req_valid <= 1'b0;
            end
        end

        while (taken_cnt < NUM_REQ) begin
            @(posedge clk);
            rsp_ready <= (next_bits(2) != '0);
        end
        repeat (4) begin
            @(posedge clk);
            rsp_ready <= 1'b1;
        end
        @(negedge clk);
        assert (!rsp_valid)
            else protocol_fail("rsp_valid still high after every result was taken");

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns, %0d of %0d results taken",
                 TIMEOUT_NS, taken_cnt, NUM_REQ);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== execute_unit.f ====
+incdir+source
source/exec_pkg.sv
source/exec_alu.sv
source/exec_branch.sv
source/exec_agu.sv
source/exec_divider.sv
source/execute_stage.sv
source/execute_unit.sv
sim/execute_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 --top-module execute_tb \
    -f execute_unit.f --Mdir "$BUILD" -o execute_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/execute_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0
